/* sim.f */
+incdir+rtl
rtl/axi_rd_pkg.sv
rtl/sync_fifo.sv
rtl/axi_rd_merger.sv
rtl/rd_burst_ctrl.sv
rtl/rd_beat_counter.sv
rtl/rd_word_mem.sv
rtl/axi_rd_subsys.sv
dv/axi_rd_tb.sv

/* Makefile */
# Verilator flow for the AXI read subsystem

VERILATOR  ?= verilator
TOP        ?= axi_rd_tb
RTL_TOP    ?= axi_rd_subsys
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Testbench passed
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/axi_rd_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/axi_rd_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "axi_rd_cfg.svh"

module axi_rd_tb;

    localparam int AW          = $clog2(`AXI_MEM_WORDS);
    localparam int NP          = `AXI_NPORTS;
    localparam int RAND_REQS   = 12;   // Per port in the random test
    localparam int HOLD_REQS   = 12;
    localparam int TOTAL_BEATS = NP * 4 + 6 + 8 + NP * 4 + NP * RAND_REQS * 8 + HOLD_REQS * 4;
    localparam int WATCHDOG    = TOTAL_BEATS * 40 + 2000;   // Margin covers load and stall waits

    logic                           clk;
    logic                           rst_n;
    axi_rd_pkg::ar_req_t            up_ar      [NP];
    logic                           up_arvalid [NP];
    logic                           up_arready [NP];
    axi_rd_pkg::r_beat_t            up_r       [NP];
    logic                           up_rvalid  [NP];
    logic                           up_rready  [NP];
    logic                           mem_we;
    logic [AW-1:0]                  mem_addr;
    logic [`AXI_DWID-1:0]           mem_wdata;

    logic [`AXI_DWID-1:0]           mem_model [`AXI_MEM_WORDS];
    axi_rd_pkg::ar_req_t            exp_q     [NP][$];
    int unsigned                    beat_idx  [NP] = '{default: 0};
    int                             done_order[$];
    logic [31:0]                    stim_state = 32'h0c4a6f1a;
    logic [31:0]                    bp_state   = 32'h0c4a6f1a;
    bit                             bp_en      = 1'b0;
    int                             hold_port  = -1;
    string                          cur_test   = "reset";
    int                             errors     = 0;
    int                             checks     = 0;
    int                             err_mark   = 0;
    int                             check_mark = 0;
    int                             tests_run  = 0;
    int                             tests_failed = 0;

    axi_rd_subsys axi_rd_subsys_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .up_ar      (up_ar),
        .up_arvalid (up_arvalid),
        .up_arready (up_arready),
        .up_r       (up_r),
        .up_rvalid  (up_rvalid),
        .up_rready  (up_rready),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ##################################################
    // Random numbers and the reference model

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic axi_rd_pkg::ar_req_t rand_req(input logic [7:0] max_len);
        axi_rd_pkg::ar_req_t r;
        logic [31:0]         v;
        r        = '0;
        v        = next_rand();
        r.id     = v[`AXI_IDWID-1:0];
        r.extras = v[8 +: `AXI_EXTRAS];
        r.burst  = v[16] ? axi_rd_pkg::INCR : axi_rd_pkg::FIXED;
        r.len    = v[31:24] % (max_len + 8'd1);
        v        = next_rand();
        r.addr   = (v % 32'd72) << 3;   // Some bursts run past the memory end
        return r;
    endfunction

    // Expected beat k of a request from the memory copy
    function automatic axi_rd_pkg::r_beat_t ref_beat(input axi_rd_pkg::ar_req_t req,
                                                     input int unsigned k);
        axi_rd_pkg::r_beat_t b;
        int unsigned         idx;
        idx = req.addr / 32'd8;
        if (req.burst == axi_rd_pkg::INCR)
            idx = idx + k;
        b.id = req.id;
        if (idx < `AXI_MEM_WORDS) begin
            b.data = mem_model[idx[AW-1:0]];
            b.resp = axi_rd_pkg::OKAY;
        end else begin
            b.data = '0;
            b.resp = axi_rd_pkg::SLVERR;
        end
        b.last = (k == 32'(req.len));
        return b;
    endfunction

    // ##################################################
    // Checker

    task automatic check_beat(input int p);
        axi_rd_pkg::r_beat_t got;
        axi_rd_pkg::r_beat_t exp;
        got = up_r[p];
        assert (exp_q[p].size() != 0) else begin
            $display("Port %0d returned a beat with no request outstanding in test %s",
                     p, cur_test);
            errors++;
        end
        if (exp_q[p].size() != 0) begin
            exp = ref_beat(exp_q[p][0], beat_idx[p]);
            checks++;
            assert (got == exp) else begin
                $display("ERROR test %s port %0d beat %0d: expected %h, actual %h",
                         cur_test, p, beat_idx[p], exp, got);
                errors++;
            end
            beat_idx[p]++;
            if (exp.last) begin
                void'(exp_q[p].pop_front());
                beat_idx[p] = 0;
                done_order.push_back(p);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (up_rvalid[p] && up_rready[p])
                    check_beat(p);
                if (up_arvalid[p] && up_arready[p])
                    exp_q[p].push_back(up_ar[p]);   // Accepted request becomes expected
            end
        end
    end

    // Response back-pressure
    initial begin
        for (int p = 0; p < NP; p++)
            up_rready[p] = 1'b1;
        forever begin
            @(posedge clk);
            bp_state = xorshift32(bp_state);
            for (int p = 0; p < NP; p++) begin
                if (p == hold_port)
                    up_rready[p] <= 1'b0;
                else if (bp_en)
                    up_rready[p] <= (bp_state[2*p +: 2] != 2'b00);
                else
                    up_rready[p] <= 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG);
        $display("Testbench failed");
        $finish;
    end

    // ##################################################
    // Stimulus

    task automatic send_req(input int p, input axi_rd_pkg::ar_req_t r);
        up_ar[p]      <= r;
        up_arvalid[p] <= 1'b1;
        @(posedge clk);
        while (!up_arready[p])
            @(posedge clk);
        up_arvalid[p] <= 1'b0;
    endtask

    task automatic send_random(input int p, input int n);
        repeat (n) send_req(p, rand_req(8'd7));
    endtask

    function automatic bit busy();
        for (int p = 0; p < NP; p++) begin
            if (exp_q[p].size() != 0)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic wait_idle();
        do
            @(negedge clk);
        while (busy());
        @(posedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        err_mark   = errors;
        check_mark = checks;
        done_order.delete();
    endtask

    task automatic end_test();
        wait_idle();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %-14s PASS  %0d beats", cur_test, checks - check_mark);
        end else begin
            tests_failed++;
            $display("test %-14s FAIL  %0d errors", cur_test, errors - err_mark);
        end
    endtask

    initial begin
        axi_rd_pkg::ar_req_t  reqs [NP];
        logic [`AXI_DWID-1:0] word;
        bit                   saw_full;
        rst_n     = 1'b0;
        mem_we    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        for (int p = 0; p < NP; p++) begin
            up_ar[p]      = '0;
            up_arvalid[p] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int w = 0; w < `AXI_MEM_WORDS; w++) begin
            word         = {next_rand(), next_rand()};
            mem_model[w] = word;
            mem_we      <= 1'b1;
            mem_addr    <= AW'(w);
            mem_wdata   <= word;
            @(posedge clk);
        end
        mem_we <= 1'b0;
        @(posedge clk);

        start_test("incr_each_port");
        for (int p = 0; p < NP; p++) begin
            reqs[p]       = rand_req(8'd0);
            reqs[p].burst = axi_rd_pkg::INCR;
            reqs[p].len   = 8'd3;
            reqs[p].addr  = (next_rand() % 32'd60) << 3;
            send_req(p, reqs[p]);
            wait_idle();
        end
        end_test();

        start_test("fixed_burst");
        reqs[1]       = rand_req(8'd0);
        reqs[1].burst = axi_rd_pkg::FIXED;
        reqs[1].len   = 8'd5;
        reqs[1].addr  = 32'd10 << 3;
        send_req(1, reqs[1]);
        end_test();

        start_test("past_mem_end");
        reqs[2]       = rand_req(8'd0);
        reqs[2].burst = axi_rd_pkg::INCR;
        reqs[2].len   = 8'd7;
        reqs[2].addr  = 32'(`AXI_MEM_WORDS - 4) << 3;   // Last four beats fall outside
        send_req(2, reqs[2]);
        end_test();

        start_test("all_ports_same");
        for (int p = 0; p < NP; p++) begin
            reqs[p]       = rand_req(8'd0);
            reqs[p].burst = axi_rd_pkg::INCR;
            reqs[p].len   = 8'd3;
        end
        fork
            send_req(0, reqs[0]);
            send_req(1, reqs[1]);
            send_req(2, reqs[2]);
            send_req(3, reqs[3]);
        join
        wait_idle();
        assert (done_order[0] == 0) else begin
            $display("ERROR test %s first port done: expected %0d, actual %0d",
                     cur_test, 0, done_order[0]);
            errors++;
        end
        end_test();

        start_test("random_traffic");
        bp_en = 1'b1;
        fork
            send_random(0, RAND_REQS);
            send_random(1, RAND_REQS);
            send_random(2, RAND_REQS);
            send_random(3, RAND_REQS);
        join
        end_test();
        bp_en = 1'b0;

        start_test("held_rready");
        hold_port = 3;
        saw_full  = 1'b0;
        @(posedge clk);
        fork
            repeat (HOLD_REQS) send_req(3, rand_req(8'd3));
            begin
                for (int i = 0; i < 200 && !saw_full; i++) begin
                    @(negedge clk);
                    saw_full = !up_arready[3];
                end
                repeat (20) @(posedge clk);
                hold_port = -1;
            end
        join
        assert (saw_full) else begin
            $display("Port d arready never fell while its responses were held");
            errors++;
        end
        end_test();

        $display("%0d tests, %0d failed, %0d beats checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/axi_rd_subsys.sv */
`default_nettype none
`timescale 1ns/100ps

`include "axi_rd_cfg.svh"

module axi_rd_subsys (
    input  wire                                clk,
    input  wire                                rst_n,

    input  axi_rd_pkg::ar_req_t                up_ar      [`AXI_NPORTS],
    input  wire                                up_arvalid [`AXI_NPORTS],
    output logic                               up_arready [`AXI_NPORTS],
    output axi_rd_pkg::r_beat_t                up_r       [`AXI_NPORTS],
    output logic                               up_rvalid  [`AXI_NPORTS],
    input  wire                                up_rready  [`AXI_NPORTS],

    input  wire                                mem_we,
    input  wire [$clog2(`AXI_MEM_WORDS)-1:0]   mem_addr,
    input  wire [`AXI_DWID-1:0]                mem_wdata
);

    axi_rd_pkg::ar_req_t     dn_ar;
    logic                    dn_arvalid;
    logic                    dn_arready;
    axi_rd_pkg::r_beat_t     dn_r;
    logic                    dn_rvalid;
    logic                    dn_rready;
    axi_rd_pkg::tag_t        rid;
    axi_rd_pkg::resp_e       resp_code;
    logic                    burst_start;
    logic                    beat_adv;
    logic                    last_beat;
    axi_rd_pkg::word_addr_t  word_addr;
    logic [`AXI_DWID-1:0]    rdata;
    logic                    in_range;

    axi_rd_merger axi_rd_merger_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .up_ar      (up_ar),
        .up_arvalid (up_arvalid),
        .up_arready (up_arready),
        .up_r       (up_r),
        .up_rvalid  (up_rvalid),
        .up_rready  (up_rready),
        .dn_ar      (dn_ar),
        .dn_arvalid (dn_arvalid),
        .dn_arready (dn_arready),
        .dn_r       (dn_r),
        .dn_rvalid  (dn_rvalid),
        .dn_rready  (dn_rready)
    );

    // ##################################################
    // Memory slave

    rd_burst_ctrl rd_burst_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ar          (dn_ar),
        .arvalid     (dn_arvalid),
        .arready     (dn_arready),
        .rvalid      (dn_rvalid),
        .rready      (dn_rready),
        .rid         (rid),
        .burst_start (burst_start),
        .beat_adv    (beat_adv),
        .last_beat   (last_beat)
    );

    rd_beat_counter rd_beat_counter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (burst_start),
        .req       (dn_ar),
        .adv       (beat_adv),
        .word_addr (word_addr),
        .last_beat (last_beat)
    );

    rd_word_mem rd_word_mem_inst (
        .clk      (clk),
        .we       (mem_we),
        .waddr    (mem_addr),
        .wdata    (mem_wdata),
        .raddr    (word_addr),
        .rdata    (rdata),
        .in_range (in_range)
    );

    always_comb begin
        if (in_range)
            resp_code = axi_rd_pkg::OKAY;
        else
            resp_code = axi_rd_pkg::SLVERR;   // Beat past the memory end
    end

    assign dn_r = '{
        id:   rid,
        data: rdata,
        resp: resp_code,
        last: last_beat
    };

endmodule

`default_nettype wire

/* rtl/rd_word_mem.sv */
`default_nettype none
`timescale 1ns/100ps

`include "axi_rd_cfg.svh"

module rd_word_mem (
    input  wire                                clk,
    input  wire                                we,
    input  wire [$clog2(`AXI_MEM_WORDS)-1:0]   waddr,
    input  wire [`AXI_DWID-1:0]                wdata,
    input  axi_rd_pkg::word_addr_t             raddr,
    output logic [`AXI_DWID-1:0]               rdata,
    output logic                               in_range
);

    localparam int AW = $clog2(`AXI_MEM_WORDS);

    logic [`AXI_DWID-1:0] mem [`AXI_MEM_WORDS];

    // Load port
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    assign in_range = (raddr < axi_rd_pkg::word_addr_t'(`AXI_MEM_WORDS));
    assign rdata    = in_range ? mem[raddr[AW-1:0]] : '0;   // Zero past the end

endmodule

`default_nettype wire

/* rtl/rd_beat_counter.sv */
`default_nettype none
`timescale 1ns/100ps

`include "axi_rd_cfg.svh"

module rd_beat_counter (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  axi_rd_pkg::ar_req_t     req,
    input  wire                     adv,
    output axi_rd_pkg::word_addr_t  word_addr,
    output logic                    last_beat
);

    localparam int WORD_LSB = $clog2(`AXI_DWID / 8);

    logic [7:0] remaining;
    logic       incr;

    assign last_beat = (remaining == 8'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= 8'd0;
            incr      <= 1'b0;
        end else if (start) begin
            remaining <= req.len;
            incr      <= (req.burst == axi_rd_pkg::INCR);   // FIXED keeps the address
        end else if (adv && !last_beat) begin
            remaining <= remaining - 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            word_addr <= req.addr[31:WORD_LSB];
        else if (adv && incr)
            word_addr <= word_addr + 1'b1;   // One word per beat
    end

endmodule

`default_nettype wire

/* rtl/rd_burst_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module rd_burst_ctrl (
    input  wire                  clk,
    input  wire                  rst_n,
    input  axi_rd_pkg::ar_req_t  ar,
    input  wire                  arvalid,
    output logic                 arready,
    output logic                 rvalid,
    input  wire                  rready,
    output axi_rd_pkg::tag_t     rid,
    output logic                 burst_start,
    output logic                 beat_adv,
    input  wire                  last_beat
);

    typedef enum logic {
        IDLE  = 1'b0,
        BURST = 1'b1
    } state_t;

    state_t state;
    state_t state_nxt;

    assign arready     = (state == IDLE);
    assign rvalid      = (state == BURST);   // Beat stays up until taken
    assign burst_start = arvalid && arready;
    assign beat_adv    = rvalid && rready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (burst_start)
                    state_nxt = BURST;
            end
            BURST: begin
                if (beat_adv && last_beat)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // ID echoed on every beat of the burst
    always_ff @(posedge clk) begin
        if (burst_start)
            rid <= ar.id;
    end

endmodule

`default_nettype wire

/* rtl/axi_rd_merger.sv */
`default_nettype none
`timescale 1ns/100ps

`include "axi_rd_cfg.svh"

module axi_rd_merger (
    input  wire                          clk,
    input  wire                          rst_n,

    input  axi_rd_pkg::ar_req_t          up_ar      [`AXI_NPORTS],
    input  wire                          up_arvalid [`AXI_NPORTS],
    output logic                         up_arready [`AXI_NPORTS],
    output axi_rd_pkg::r_beat_t          up_r       [`AXI_NPORTS],
    output logic                         up_rvalid  [`AXI_NPORTS],
    input  wire                          up_rready  [`AXI_NPORTS],

    output axi_rd_pkg::ar_req_t          dn_ar,
    output logic                         dn_arvalid,
    input  wire                          dn_arready,
    input  axi_rd_pkg::r_beat_t          dn_r,
    input  wire                          dn_rvalid,
    output logic                         dn_rready
);

    axi_rd_pkg::ar_req_t     ar_head  [`AXI_NPORTS];
    axi_rd_pkg::tag_t        id_head  [`AXI_NPORTS];
    logic [`AXI_NPORTS-1:0]  ar_empty;
    logic [`AXI_NPORTS-1:0]  ar_full;
    logic [`AXI_NPORTS-1:0]  id_empty;
    logic [`AXI_NPORTS-1:0]  id_full;
    logic [`AXI_NPORTS-1:0]  id_pop;
    logic [`AXI_NPORTS-1:0]  eligible;
    logic [`AXI_NPORTS-1:0]  grant;
    logic [`AXI_NPORTS-1:0]  take;
    logic [`AXI_NPORTS-1:0]  tag_hit;

    // ##################################################
    // Per-port request and ID queues

    for (genvar p = 0; p < `AXI_NPORTS; p++) begin : g_port
        localparam axi_rd_pkg::tag_t TAG = axi_rd_pkg::tag_t'(`AXI_TAG_BASE + p);

        sync_fifo #(
            .item_t (axi_rd_pkg::ar_req_t),
            .DEPTH  (`AXI_AR_DEPTH)
        ) ar_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (up_arvalid[p] && !ar_full[p]),
            .din   (up_ar[p]),
            .pop   (take[p]),
            .dout  (ar_head[p]),
            .empty (ar_empty[p]),
            .full  (ar_full[p])
        );

        // Original IDs wait here until their last beat
        sync_fifo #(
            .item_t (axi_rd_pkg::tag_t),
            .DEPTH  (`AXI_ID_DEPTH)
        ) ids_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (take[p]),
            .din   (ar_head[p].id),
            .pop   (id_pop[p]),
            .dout  (id_head[p]),
            .empty (id_empty[p]),
            .full  (id_full[p])
        );

        assign up_arready[p] = !ar_full[p];
        assign eligible[p]   = !ar_empty[p] && !id_full[p];   // No grant without ID room
        assign take[p]       = grant[p] && dn_arready;

        assign tag_hit[p]    = (dn_r.id == TAG);
        assign up_rvalid[p]  = dn_rvalid && tag_hit[p] && !id_empty[p];
        assign id_pop[p]     = up_rvalid[p] && up_rready[p] && dn_r.last;

        assign up_r[p] = '{
            id:   id_head[p],
            data: dn_r.data,
            resp: dn_r.resp,
            last: dn_r.last
        };
    end

    // ##################################################
    // Fixed priority grant, port a first

    assign grant      = eligible & (~eligible + 1'b1);   // Lowest set bit
    assign dn_arvalid = |eligible;

    always_comb begin
        dn_ar = '0;
        for (int p = 0; p < `AXI_NPORTS; p++) begin
            if (grant[p]) begin
                dn_ar    = ar_head[p];
                dn_ar.id = axi_rd_pkg::tag_t'(`AXI_TAG_BASE + p);   // Port tag replaces ID
            end
        end
    end

    // ##################################################
    // Response steering by tag

    always_comb begin
        dn_rready = 1'b0;
        for (int p = 0; p < `AXI_NPORTS; p++) begin
            if (tag_hit[p])
                dn_rready = up_rready[p];
        end
    end

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module sync_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 2
) (
    input  wire   clk,
    input  wire   rst_n,
    input  wire   push,
    input  item_t din,
    input  wire   pop,
    output item_t dout,
    output logic  empty,
    output logic  full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t         mem [DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;   // Wrap for any depth
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);   // Full queue still takes a push on pop
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

endmodule

`default_nettype wire

/* rtl/axi_rd_pkg.sv */
`default_nettype none

`include "axi_rd_cfg.svh"

package axi_rd_pkg;

    // Original IDs and port tags share the ID field
    typedef logic [`AXI_IDWID-1:0] tag_t;

    // Word index of a byte address
    typedef logic [31-$clog2(`AXI_DWID/8):0] word_addr_t;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        tag_t                    id;
        logic [31:0]             addr;
        logic [7:0]              len;     // Beats minus one
        logic [`AXI_EXTRAS-1:0]  extras;
        burst_e                  burst;
    } ar_req_t;

    typedef struct packed {
        tag_t                    id;
        logic [`AXI_DWID-1:0]    data;
        resp_e                   resp;
        logic                    last;
    } r_beat_t;

endpackage

`default_nettype wire

/* rtl/axi_rd_cfg.svh */
`ifndef AXI_RD_CFG_SVH
`define AXI_RD_CFG_SVH

// AXI field widths
`define AXI_IDWID     4
`define AXI_DWID      64
`define AXI_EXTRAS    8

// Queue depths
`define AXI_AR_DEPTH  2
`define AXI_ID_DEPTH  8

// Slave memory size in words
`define AXI_MEM_WORDS 64

`define AXI_NPORTS    4
`define AXI_TAG_BASE  5     // Port a tag with b to d after it

`endif
